// File: Makefile
VERILATOR ?= verilator
TOP ?= core_tb
FLIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "make test    build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean   remove $(OBJ_DIR) and $(LOG)"
	@echo "make help    show this list"
	@echo "overridable: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/commit_stage.sv
`timescale 1ns/10ps
`include "core_params.svh"

module commit_stage (
	input logic clk,
	input logic nrst,
	input core_pkg::result_t res,
	output core_pkg::result_t wb,
	output logic commit_val,
	output logic [`CORE_XLEN-1:0] commit_pc,
	output logic [$clog2(`CORE_NREG)-1:0] commit_rd,
	output logic [`CORE_XLEN-1:0] commit_data
);

	// Last pipe register, drives retirement and write-back
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			wb <= '0;
		else
		begin
			wb.valid <= res.valid;
			wb.pc <= res.pc;
			wb.rd <= res.rd;
			wb.we <= res.we && (res.rd != '0);	// x0 writes dropped here
			wb.data <= res.data;
		end
	end

	assign commit_val = wb.valid;	// One pulse per retired instruction
	assign commit_pc = wb.pc;
	assign commit_rd = wb.rd;
	assign commit_data = wb.data;	// Reported even for rd x0

endmodule

// File: design/core.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core (
	input logic clk,
	input logic nrst,
	input logic debug_sig,
	input logic [`CORE_XLEN-1:0] debug_addr,
	input logic [`CORE_XLEN-1:0] debug_instr,
	output logic commit_val,
	output logic [`CORE_XLEN-1:0] commit_pc,
	output logic [$clog2(`CORE_NREG)-1:0] commit_rd,
	output logic [`CORE_XLEN-1:0] commit_data
);

	core_pkg::fetch_t fetch;	// Frontend to decode
	core_pkg::uop_t uop;		// Decode to issue
	core_pkg::exe_t exe;		// Issue to execute
	core_pkg::result_t res;		// Execute to commit
	core_pkg::result_t wb;		// Commit back to regfile and bypass

	frontend_stage frontend (
		.clk(clk),
		.nrst(nrst),
		.debug_sig(debug_sig),
		.debug_addr(debug_addr),
		.debug_instr(debug_instr),
		.fetch(fetch)
	);

	instdec_stage instdec (.clk(clk), .nrst(nrst), .fetch(fetch), .uop(uop));

	issue_stage issue (.clk(clk), .nrst(nrst), .uop(uop), .wb(wb), .exe(exe));

	exe_stage execute (.clk(clk), .nrst(nrst), .exe(exe), .wb(wb), .res(res));

	commit_stage commit (
		.clk(clk),
		.nrst(nrst),
		.res(res),
		.wb(wb),
		.commit_val(commit_val),
		.commit_pc(commit_pc),
		.commit_rd(commit_rd),
		.commit_data(commit_data)
	);

endmodule

// File: design/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and instruction width
`define CORE_XLEN 32

// Architectural registers x0..x31
`define CORE_NREG 32

// Private instruction memory, in words
`define CORE_IMEM_DEPTH 64
`define CORE_IMEM_AW 6

`endif

// File: design/core_pkg.sv
`include "core_params.svh"

package core_pkg;

	// ALU function codes
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b	// LUI result is operand b
	} alu_op_e;

	// Frontend to decode
	typedef struct packed {
		logic valid;
		logic [`CORE_XLEN-1:0] pc;
		logic [`CORE_XLEN-1:0] instr;
	} fetch_t;

	// Decoded micro-op
	typedef struct packed {
		logic valid;
		logic [`CORE_XLEN-1:0] pc;
		alu_op_e op;
		logic [$clog2(`CORE_NREG)-1:0] rs1;
		logic [$clog2(`CORE_NREG)-1:0] rs2;
		logic [$clog2(`CORE_NREG)-1:0] rd;
		logic we;
		logic use_imm;	// Operand b from imm
		logic zero_a;	// Operand a forced to 0
		logic [`CORE_XLEN-1:0] imm;
	} uop_t;

	// Issue to execute, operands already read
	typedef struct packed {
		logic valid;
		logic [`CORE_XLEN-1:0] pc;
		alu_op_e op;
		logic [$clog2(`CORE_NREG)-1:0] rs1;
		logic [$clog2(`CORE_NREG)-1:0] rs2;
		logic [$clog2(`CORE_NREG)-1:0] rd;
		logic we;
		logic [`CORE_XLEN-1:0] opa;
		logic [`CORE_XLEN-1:0] opb;
		logic a_reg;	// opa came from rs1, bypass allowed
		logic b_reg;	// opb came from rs2
	} exe_t;

	// ALU result, also the write-back port
	typedef struct packed {
		logic valid;
		logic [`CORE_XLEN-1:0] pc;
		logic [$clog2(`CORE_NREG)-1:0] rd;
		logic we;
		logic [`CORE_XLEN-1:0] data;
	} result_t;

endpackage

// File: design/exe_stage.sv
`timescale 1ns/10ps
`include "core_params.svh"

module exe_stage (
	input logic clk,
	input logic nrst,
	input core_pkg::exe_t exe,
	input core_pkg::result_t wb,	// Older bypass source
	output core_pkg::result_t res
);

	logic [`CORE_XLEN-1:0] a, b;
	logic [`CORE_XLEN-1:0] alu_out;
	logic [4:0] shamt;

	// Younger producer first, then commit register
	function automatic logic [`CORE_XLEN-1:0] fwd(
		input logic [`CORE_XLEN-1:0] val,
		input logic [$clog2(`CORE_NREG)-1:0] idx,
		input logic from_reg
	);
		if (!from_reg || idx == '0)
			return val;
		else if (res.valid && res.we && res.rd == idx)
			return res.data;		// Distance 1
		else if (wb.valid && wb.we && wb.rd == idx)
			return wb.data;			// Distance 2
		else
			return val;
	endfunction

	assign a = fwd(exe.opa, exe.rs1, exe.a_reg);
	assign b = fwd(exe.opb, exe.rs2, exe.b_reg);
	assign shamt = b[4:0];

	always_comb
	begin
		case (exe.op)
			core_pkg::alu_add: alu_out = a + b;
			core_pkg::alu_sub: alu_out = a - b;
			core_pkg::alu_sll: alu_out = a << shamt;
			core_pkg::alu_slt: alu_out = {31'b0, $signed(a) < $signed(b)};
			core_pkg::alu_sltu: alu_out = {31'b0, a < b};
			core_pkg::alu_xor: alu_out = a ^ b;
			core_pkg::alu_srl: alu_out = a >> shamt;
			core_pkg::alu_sra: alu_out = $signed(a) >>> shamt;	// Keeps sign bit
			core_pkg::alu_or: alu_out = a | b;
			core_pkg::alu_and: alu_out = a & b;
			default: alu_out = b;		// pass_b
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			res <= '0;
		else
		begin
			res.valid <= exe.valid;
			res.pc <= exe.pc;
			res.rd <= exe.rd;
			res.we <= exe.we;
			res.data <= alu_out;
		end
	end

endmodule

// File: design/frontend_stage.sv
`timescale 1ns/10ps
`include "core_params.svh"

module frontend_stage (
	input logic clk,
	input logic nrst,
	input logic debug_sig,				// Load mode level
	input logic [`CORE_XLEN-1:0] debug_addr,	// Byte address of the word to load
	input logic [`CORE_XLEN-1:0] debug_instr,
	output core_pkg::fetch_t fetch
);

	logic [`CORE_XLEN-1:0] imem [`CORE_IMEM_DEPTH];
	logic [`CORE_XLEN-1:0] pc;
	logic run;					// Set one cycle after load mode ends
	logic [`CORE_IMEM_AW-1:0] waddr;
	logic [`CORE_IMEM_AW-1:0] raddr;

	assign waddr = debug_addr[`CORE_IMEM_AW+1:2];	// Word index from byte address
	assign raddr = pc[`CORE_IMEM_AW+1:2];

	// Instruction memory, written only by the debug port
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `CORE_IMEM_DEPTH; i++)
				imem[i] <= '0;			// Zero word decodes as a bubble
		end
		else if (debug_sig)
			imem[waddr] <= debug_instr;
	end

	// Program counter and fetch register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc <= '0;
			run <= 1'b0;
			fetch <= '0;
		end
		else if (debug_sig)
		begin
			pc <= '0;			// Restart point for the next program
			run <= 1'b0;
			fetch.valid <= 1'b0;		// Drains everything downstream
		end
		else
		begin
			run <= 1'b1;
			fetch.valid <= run;		// First valid fetch one cycle after load ends
			fetch.pc <= pc;
			fetch.instr <= imem[raddr];
			if (run)
				pc <= pc + `CORE_XLEN'd4;
		end
	end

endmodule

// File: design/instdec_stage.sv
`timescale 1ns/10ps

module instdec_stage (
	input logic clk,
	input logic nrst,
	input core_pkg::fetch_t fetch,
	output core_pkg::uop_t uop
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd, rs1, rs2;
	logic legal;
	core_pkg::alu_op_e f3_op;	// Common funct3 mapping for OP and OP-IMM
	core_pkg::uop_t dec;

	assign opcode = fetch.instr[6:0];
	assign rd = fetch.instr[11:7];
	assign funct3 = fetch.instr[14:12];
	assign rs1 = fetch.instr[19:15];
	assign rs2 = fetch.instr[24:20];
	assign funct7 = fetch.instr[31:25];

	always_comb
	begin
		case (funct3)
			3'b000: f3_op = core_pkg::alu_add;
			3'b001: f3_op = core_pkg::alu_sll;
			3'b010: f3_op = core_pkg::alu_slt;
			3'b011: f3_op = core_pkg::alu_sltu;
			3'b100: f3_op = core_pkg::alu_xor;
			3'b101: f3_op = core_pkg::alu_srl;	// sra picked below by funct7
			3'b110: f3_op = core_pkg::alu_or;
			default: f3_op = core_pkg::alu_and;
		endcase
	end

	always_comb
	begin
		dec = '0;
		legal = 1'b0;
		dec.pc = fetch.pc;
		dec.rd = rd;
		dec.rs1 = rs1;
		dec.we = 1'b1;
		dec.use_imm = 1'b1;
		dec.op = f3_op;
		dec.imm = {{20{fetch.instr[31]}}, fetch.instr[31:20]};	// I-type, sign extended
		case (opcode)
			7'b0110111:	// LUI
			begin
				legal = 1'b1;
				dec.op = core_pkg::alu_pass_b;
				dec.zero_a = 1'b1;
				dec.rs1 = '0;
				dec.imm = {fetch.instr[31:12], 12'b0};
			end
			7'b0010011:	// OP-IMM
			begin
				legal = 1'b1;
				if (funct3 == 3'b001 || funct3 == 3'b101)
				begin
					dec.imm = {27'b0, fetch.instr[24:20]};	// shamt only
					legal = (funct7 == 7'b0000000) ||
						(funct3 == 3'b101 && funct7 == 7'b0100000);
					if (funct7[5])
						dec.op = core_pkg::alu_sra;
				end
			end
			7'b0110011:	// OP
			begin
				dec.use_imm = 1'b0;
				dec.rs2 = rs2;
				if (funct7 == 7'b0000000)
					legal = 1'b1;
				else if (funct7 == 7'b0100000)
				begin
					legal = (funct3 == 3'b000) || (funct3 == 3'b101);
					dec.op = (funct3 == 3'b000) ? core_pkg::alu_sub : core_pkg::alu_sra;
				end
			end
			default: legal = 1'b0;	// Everything else is a bubble
		endcase
		dec.valid = fetch.valid && legal;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			uop <= '0;
		else
			uop <= dec;
	end

endmodule

// File: design/issue_stage.sv
`timescale 1ns/10ps
`include "core_params.svh"

module issue_stage (
	input logic clk,
	input logic nrst,
	input core_pkg::uop_t uop,
	input core_pkg::result_t wb,	// Register file write port from commit
	output core_pkg::exe_t exe
);

	logic [`CORE_XLEN-1:0] rf [`CORE_NREG];
	logic wr_en;
	logic [`CORE_XLEN-1:0] rs1_val;
	logic [`CORE_XLEN-1:0] rs2_val;

	assign wr_en = wb.valid && wb.we && (wb.rd != '0);

	// Read port with write-through, covers distance 3
	function automatic logic [`CORE_XLEN-1:0] read_reg(
		input logic [$clog2(`CORE_NREG)-1:0] idx
	);
		if (idx == '0)
			return '0;			// x0 hardwired
		else if (wr_en && wb.rd == idx)
			return wb.data;			// Same-cycle write wins
		else
			return rf[idx];
	endfunction

	assign rs1_val = read_reg(uop.rs1);
	assign rs2_val = read_reg(uop.rs2);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `CORE_NREG; i++)
				rf[i] <= '0;
		end
		else if (wr_en)
			rf[wb.rd] <= wb.data;
	end

	// Operand select and pipe register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			exe <= '0;
		else
		begin
			exe.valid <= uop.valid;
			exe.pc <= uop.pc;
			exe.op <= uop.op;
			exe.rs1 <= uop.rs1;
			exe.rs2 <= uop.rs2;
			exe.rd <= uop.rd;
			exe.we <= uop.we;
			exe.opa <= uop.zero_a ? '0 : rs1_val;		// LUI adds to zero
			exe.opb <= uop.use_imm ? uop.imm : rs2_val;
			exe.a_reg <= !uop.zero_a;
			exe.b_reg <= !uop.use_imm;	// Immediates never bypassed
		end
	end

endmodule

// File: tests/core_tb.sv
`timescale 1ns/10ps
`include "core_params.svh"

module core_tb;

	localparam int PROG_WORDS = 16;	// Words written per load including zero padding
	localparam int LAT = 5;		// Edges from debug release to first commit
	localparam int DRAIN = 3;	// Quiet cycles checked after the program

	typedef struct packed {
		logic [`CORE_XLEN-1:0] instr;
		logic commit;			// Expected to retire
		logic [4:0] rd;
		logic [`CORE_XLEN-1:0] value;
	} entry_t;

	logic clk;
	logic nrst;
	logic debug_sig;
	logic [`CORE_XLEN-1:0] debug_addr;
	logic [`CORE_XLEN-1:0] debug_instr;
	logic commit_val;
	logic [`CORE_XLEN-1:0] commit_pc;
	logic [4:0] commit_rd;
	logic [`CORE_XLEN-1:0] commit_data;

	entry_t tbl[$];			// Stimulus and expected results
	int run_first[$];		// First table index of each program
	int run_abort[$];		// Instructions fetched before abort or 0
	string run_name[$];
	logic [31:0] lcg_state;
	int errors;
	int test_errors;
	int cycles = 0;
	int limit = 0;

	core dut0 (
		.clk(clk),
		.nrst(nrst),
		.debug_sig(debug_sig),
		.debug_addr(debug_addr),
		.debug_instr(debug_instr),
		.commit_val(commit_val),
		.commit_pc(commit_pc),
		.commit_rd(commit_rd),
		.commit_data(commit_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run length guard
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// RV32I encoders
	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	// OP-IMM result per the ISA without shifts
	function automatic logic [31:0] op_imm_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [11:0] imm);
		logic [31:0] b;
		b = {{20{imm[11]}}, imm};
		case (f3)
			3'b000: return a + b;
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic add_entry(input logic [31:0] instr, input logic commit,
		input logic [4:0] rd, input logic [31:0] value);
		tbl.push_back({instr, commit, rd, value});
	endtask

	task automatic new_run(input string name, input int abort);
		run_first.push_back(tbl.size());
		run_abort.push_back(abort);
		run_name.push_back(name);
	endtask

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
			count_error();
		end
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [11:0] imm;
		logic [2:0] f3;
		logic [31:0] val;
		logic [26:0] f3_list;
		f3_list = {3'd0, 3'd4, 3'd6, 3'd3, 3'd2, 3'd7, 3'd6, 3'd4, 3'd0};
		new_run("lui and immediate ops", 0);
		add_entry(enc_u(20'h12345, 1), 1, 1, 32'h12345000);
		add_entry(enc_i(12'h678, 1, 3'b000, 2), 1, 2, 32'h12345678);	// x1 at distance 1
		add_entry(enc_i(12'hfff, 0, 3'b000, 3), 1, 3, 32'hffffffff);
		add_entry(enc_i(12'h000, 3, 3'b010, 4), 1, 4, 32'h00000001);	// slti
		add_entry(enc_i(12'h001, 3, 3'b011, 5), 1, 5, 32'h00000000);	// sltiu
		add_entry(enc_i(12'h0ff, 2, 3'b100, 6), 1, 6, 32'h12345687);
		add_entry(enc_i(12'h00f, 1, 3'b110, 7), 1, 7, 32'h1234500f);
		add_entry(enc_i(12'h0f0, 2, 3'b111, 8), 1, 8, 32'h00000070);
		add_entry(enc_i(12'h004, 2, 3'b001, 9), 1, 9, 32'h23456780);	// slli 4
		add_entry(enc_i(12'h01c, 3, 3'b101, 10), 1, 10, 32'h0000000f);	// srli 28
		add_entry(enc_u(20'h80000, 12), 1, 12, 32'h80000000);
		add_entry(enc_i(12'h404, 12, 3'b101, 11), 1, 11, 32'hf8000000);	// srai 4
		new_run("register ops with bypass", 0);
		add_entry(enc_i(12'd100, 0, 3'b000, 13), 1, 13, 32'd100);
		add_entry(enc_i(12'hff9, 0, 3'b000, 14), 1, 14, 32'hfffffff9);
		add_entry(enc_r(7'h00, 14, 13, 3'b000, 15), 1, 15, 32'd93);	// Distances 1 and 2
		add_entry(enc_r(7'h20, 14, 13, 3'b000, 16), 1, 16, 32'd107);	// x13 at distance 3
		add_entry(enc_r(7'h00, 15, 13, 3'b001, 17), 1, 17, 32'h80000000);
		add_entry(enc_r(7'h00, 13, 14, 3'b010, 18), 1, 18, 32'd1);
		add_entry(enc_r(7'h00, 13, 14, 3'b011, 19), 1, 19, 32'd0);
		add_entry(enc_r(7'h00, 17, 16, 3'b100, 20), 1, 20, 32'h8000006b);
		add_entry(enc_r(7'h00, 18, 17, 3'b101, 21), 1, 21, 32'h40000000);
		add_entry(enc_r(7'h20, 18, 17, 3'b101, 22), 1, 22, 32'hc0000000);	// sra
		add_entry(enc_r(7'h00, 22, 21, 3'b110, 23), 1, 23, 32'hc0000000);
		add_entry(enc_r(7'h00, 20, 23, 3'b111, 24), 1, 24, 32'h80000000);
		new_run("bubbles keep pcs", 0);
		add_entry(enc_i(12'd5, 0, 3'b000, 25), 1, 25, 32'd5);
		add_entry(32'h00000000, 0, 0, 32'd0);
		add_entry(enc_i(12'd3, 25, 3'b000, 26), 1, 26, 32'd8);
		add_entry(enc_r(7'h20, 0, 26, 3'b100, 27), 0, 27, 32'd0);	// No xor with funct7 0x20
		add_entry(enc_r(7'h00, 25, 26, 3'b000, 28), 1, 28, 32'd13);
		add_entry(enc_r(7'h00, 28, 27, 3'b000, 29), 1, 29, 32'd13);	// x27 still zero
		new_run("writes to x0", 0);
		add_entry(enc_i(12'd55, 0, 3'b000, 0), 1, 0, 32'd55);	// Retires with its data shown
		add_entry(enc_r(7'h00, 0, 0, 3'b000, 30), 1, 30, 32'd0);
		add_entry(enc_i(12'd9, 0, 3'b000, 31), 1, 31, 32'd9);
		add_entry(enc_r(7'h20, 0, 31, 3'b000, 31), 1, 31, 32'd9);
		new_run("abort mid-program", 2);
		add_entry(enc_i(12'd11, 0, 3'b000, 5), 1, 5, 32'd11);
		add_entry(enc_i(12'd22, 5, 3'b000, 6), 1, 6, 32'd33);
		add_entry(enc_i(12'd999, 0, 3'b000, 5), 1, 5, 32'd999);	// Never fetched
		add_entry(enc_i(12'd999, 0, 3'b000, 6), 1, 6, 32'd999);
		new_run("restart keeps registers", 0);
		add_entry(enc_r(7'h00, 6, 5, 3'b000, 7), 1, 7, 32'd44);
		add_entry(enc_r(7'h20, 5, 6, 3'b000, 8), 1, 8, 32'd22);
		add_entry(enc_r(7'h00, 8, 7, 3'b100, 9), 1, 9, 32'd58);
		new_run("random immediates", 0);
		r = lcg_next();
		imm = r[27:16];
		val = op_imm_ref(3'b000, 32'd0, imm);
		add_entry(enc_i(imm, 0, 3'b000, 10), 1, 10, val);
		for (int i = 1; i < 10; i++)
		begin
			r = lcg_next();
			imm = r[27:16];
			f3 = f3_list[3 * (i - 1) +: 3];
			val = op_imm_ref(f3, val, imm);		// Chain through the previous rd
			add_entry(enc_i(imm, 5'(9 + i), f3, 5'(10 + i)), 1, 5'(10 + i), val);
		end
	endtask

	// Debug port writes zero padded to PROG_WORDS
	task automatic load_prog(input int first, input int len);
		for (int i = 0; i < PROG_WORDS; i++)
		begin
			@(posedge clk);
			debug_sig <= 1'b1;
			debug_addr <= 32'(4 * i);
			if (i < len)
				debug_instr <= tbl[first + i].instr;
			else
				debug_instr <= '0;
		end
	endtask

	// Cycle-exact check of the retirement stream
	task automatic run_prog(input int first, input int len, input int abort);
		int fetched;
		int k;
		logic exp_v;
		entry_t e;
		fetched = (abort > 0) ? abort : len;
		@(posedge clk);
		debug_sig <= 1'b0;			// Last word lands on this edge
		for (int c = 0; c < len + LAT + DRAIN; c++)
		begin
			@(posedge clk);
			if (abort > 0 && c == abort)
				debug_sig <= 1'b1;		// Fetch stops on the next edge
			@(negedge clk);
			k = c - LAT;
			exp_v = 1'b0;
			e = '0;
			if (k >= 0 && k < fetched)
			begin
				e = tbl[first + k];
				exp_v = e.commit;
			end
			if (commit_val !== exp_v)
			begin
				if (exp_v)
					$display("missing commit for pc %h at %0t", 32'(4 * k), $time);
				else
					$display("unexpected commit of pc %h at %0t", commit_pc, $time);
				count_error();
			end
			else if (exp_v)
			begin
				compare_value("commit_pc", commit_pc, 32'(4 * k));
				compare_value("commit_rd", {27'b0, commit_rd}, {27'b0, e.rd});
				compare_value("commit_data", commit_data, e.value);
			end
		end
	endtask

	initial
	begin
		int first;
		int len;
		int passed;
		int failed;
		nrst <= 1'b0;
		debug_sig <= 1'b0;
		debug_addr <= '0;
		debug_instr <= '0;
		lcg_state = 32'd68536;
		errors = 0;
		passed = 0;
		failed = 0;
		build_table();
		limit = tbl.size() * 2 + run_first.size() * (PROG_WORDS + 1) + 30;
		repeat (5) @(posedge clk);
		nrst <= 1'b1;
		for (int r = 0; r < run_first.size(); r++)
		begin
			first = run_first[r];
			if (r + 1 < run_first.size())
				len = run_first[r + 1] - first;
			else
				len = tbl.size() - first;
			test_errors = 0;
			load_prog(first, len);
			run_prog(first, len, run_abort[r]);
			if (test_errors == 0)
			begin
				passed++;
				$display("test %0d %s: ok", r, run_name[r]);
			end
			else
			begin
				failed++;
				$display("test %0d %s: failed with %0d errors", r, run_name[r], test_errors);
			end
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", passed + failed, passed,
			failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
design/core_pkg.sv
design/frontend_stage.sv
design/instdec_stage.sv
design/issue_stage.sv
design/exe_stage.sv
design/commit_stage.sv
design/core.sv
tests/core_tb.sv
